/* hdl/filter_pkg.sv */
package filter_pkg;

	////////////////////////////////////////////////////////////
	// header field values as they sit in the little-endian beat
	////////////////////////////////////////////////////////////

	localparam logic [15:0] eth_type_ipv4 = 16'h0008;	// 0x0800 byte-swapped
	localparam logic [7:0]  ipprot_udp    = 8'h11;
	localparam logic [15:0] control_port  = 16'hf2f1;	// udp port of the control path

	// low bit of each header field, vlan tag included
	localparam int eth_type_lsb  = 128;
	localparam int ip_prot_lsb   = 216;
	localparam int udp_dport_lsb = 320;
	localparam int cmd_lsb       = 336;

	localparam int egress_lsb = 24;	// egress field inside tuser
	localparam int egress_w   = 8;

	localparam int table_idx_w = 6;	// 64 table entries

	////////////////////////////////////////////////////////////
	// control command word
	////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		op_nop         = 2'd0,
		op_write_entry = 2'd1,
		op_fill_range  = 2'd2
	} ctrl_op_e;

	// op is in bits 1:0 in both views, so either view may be read to find it
	typedef union packed {
		struct packed {
			logic [15:0]            unused;
			logic [egress_w-1:0]    egress;
			logic [table_idx_w-1:0] index;
			ctrl_op_e               op;
		} as_write;
		struct packed {
			logic [7:0]             unused_hi;
			logic [egress_w-1:0]    egress;
			logic [1:0]             unused_mid;
			logic [table_idx_w-1:0] last;
			logic [table_idx_w-1:0] first;
			ctrl_op_e               op;
		} as_fill;
	} ctrl_cmd_u;

endpackage

/* hdl/pkt_filter.sv */
module pkt_filter #(
	parameter int DATA_WIDTH  = 512,
	parameter int TUSER_WIDTH = 128
) (
	input  logic                    clk,
	input  logic                    aresetn,

	input  logic [DATA_WIDTH-1:0]   s_tdata,
	input  logic [DATA_WIDTH/8-1:0] s_tkeep,
	input  logic [TUSER_WIDTH-1:0]  s_tuser,
	input  logic                    s_tvalid,
	output logic                    s_tready,
	input  logic                    s_tlast,

	output logic [DATA_WIDTH-1:0]   d_tdata,
	output logic [DATA_WIDTH/8-1:0] d_tkeep,
	output logic [TUSER_WIDTH-1:0]  d_tuser,
	output logic                    d_tvalid,
	input  logic                    d_tready,
	output logic                    d_tlast,

	output logic [DATA_WIDTH-1:0]   c_tdata,
	output logic                    c_tvalid,
	output logic                    c_tlast
);

	localparam logic [1:0] wait_first = 2'd0;
	localparam logic [1:0] pass_data  = 2'd1;
	localparam logic [1:0] pass_ctl   = 2'd2;
	localparam logic [1:0] drop       = 2'd3;

	logic [1:0]             state;
	logic [1:0]             state_next;
	logic                   out_en;
	logic                   is_udp;
	logic                   is_ctl;
	logic                   keep_beat;
	logic                   to_ctl;
	logic                   s_fire;
	logic                   drain;

	logic                   r_valid;
	logic                   r_ctl;	// set when the held beat belongs to the control path
	logic [DATA_WIDTH-1:0]  r_data;
	logic [DATA_WIDTH/8-1:0] r_keep;
	logic [TUSER_WIDTH-1:0] r_user;
	logic                   r_last;

	assign is_udp = (s_tdata[filter_pkg::eth_type_lsb +: 16] == filter_pkg::eth_type_ipv4) &&
		(s_tdata[filter_pkg::ip_prot_lsb +: 8] == filter_pkg::ipprot_udp);
	assign is_ctl = (s_tdata[filter_pkg::udp_dport_lsb +: 16] == filter_pkg::control_port);

	// a control beat leaves the register every cycle since that path never stalls
	assign drain    = r_valid & (r_ctl | d_tready);
	assign s_tready = out_en & (~r_valid | drain);
	assign s_fire   = s_tvalid & s_tready;

	always_comb begin
		state_next = state;
		keep_beat  = 1'b0;
		to_ctl     = 1'b0;
		case (state)
			wait_first: begin
				keep_beat = is_udp;
				to_ctl    = is_udp & is_ctl;
				if (!is_udp)
					state_next = drop;
				else if (is_ctl)
					state_next = pass_ctl;
				else
					state_next = pass_data;
			end
			pass_data: keep_beat = 1'b1;
			pass_ctl: begin
				keep_beat = 1'b1;
				to_ctl    = 1'b1;
			end
			default: keep_beat = 1'b0;	// drop until tlast
		endcase
		if (!s_fire)
			state_next = state;
		else if (s_tlast)
			state_next = wait_first;	// also covers single-beat packets
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state   <= wait_first;
			out_en  <= 1'b0;
			r_valid <= 1'b0;
			r_ctl   <= 1'b0;
		end else begin
			state  <= state_next;
			out_en <= 1'b1;
			if (s_fire && keep_beat) begin
				r_valid <= 1'b1;
				r_ctl   <= to_ctl;
			end else if (drain) begin
				r_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (s_fire && keep_beat) begin
			r_data <= s_tdata;
			r_keep <= s_tkeep;
			r_user <= s_tuser;
			r_last <= s_tlast;
		end
	end

	assign d_tdata  = r_data;
	assign d_tkeep  = r_keep;
	assign d_tuser  = r_user;
	assign d_tlast  = r_last;
	assign d_tvalid = r_valid & ~r_ctl;

	assign c_tdata  = r_data;
	assign c_tlast  = r_last;
	assign c_tvalid = r_valid & r_ctl;

endmodule

/* hdl/ctrl_decoder.sv */
module ctrl_decoder #(
	parameter int DATA_WIDTH = 512
) (
	input  logic                                clk,
	input  logic                                aresetn,

	input  logic [DATA_WIDTH-1:0]               c_tdata,
	input  logic                                c_tvalid,
	input  logic                                c_tlast,
	input  logic                                busy,

	output logic                                wr_start,
	output logic [filter_pkg::table_idx_w-1:0]  wr_first,
	output logic [filter_pkg::table_idx_w-1:0]  wr_last,
	output logic [filter_pkg::egress_w-1:0]     wr_egress
);

	logic                  c_first;	// next control beat opens a packet
	logic                  take;
	filter_pkg::ctrl_cmd_u cmd;

	assign cmd  = c_tdata[filter_pkg::cmd_lsb +: 32];
	assign take = c_tvalid & c_first & ~busy;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			c_first  <= 1'b1;
			wr_start <= 1'b0;
		end else begin
			if (c_tvalid)
				c_first <= c_tlast;
			wr_start <= take && (cmd.as_write.op == filter_pkg::op_write_entry ||
				cmd.as_write.op == filter_pkg::op_fill_range);
		end
	end

	////////////////////////////////////////////////////////////
	// request fields, only meaningful alongside wr_start
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (take) begin
			case (cmd.as_write.op)
				filter_pkg::op_write_entry: begin
					wr_first  <= cmd.as_write.index;
					wr_last   <= cmd.as_write.index;	// single entry is a range of one
					wr_egress <= cmd.as_write.egress;
				end
				filter_pkg::op_fill_range: begin
					wr_first  <= cmd.as_fill.first;
					wr_last   <= cmd.as_fill.last;
					wr_egress <= cmd.as_fill.egress;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

/* hdl/port_table.sv */
module port_table (
	input  logic                                clk,
	input  logic                                aresetn,

	input  logic                                wr_start,
	input  logic [filter_pkg::table_idx_w-1:0]  wr_first,
	input  logic [filter_pkg::table_idx_w-1:0]  wr_last,
	input  logic [filter_pkg::egress_w-1:0]     wr_egress,
	output logic                                busy,

	input  logic [filter_pkg::table_idx_w-1:0]  lk_index,
	output logic [filter_pkg::egress_w-1:0]     lk_egress
);

	localparam int depth = 2 ** filter_pkg::table_idx_w;

	logic [filter_pkg::egress_w-1:0]    tbl [depth];
	logic [filter_pkg::table_idx_w-1:0] cur;	// index written this cycle
	logic [filter_pkg::table_idx_w-1:0] stop;
	logic [filter_pkg::egress_w-1:0]    egr;

	////////////////////////////////////////////////////////////
	// range walker, one entry per cycle
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			busy <= 1'b0;
			cur  <= '0;
			stop <= '0;
			egr  <= '0;
		end else if (busy) begin
			// a reversed range stops right after writing first
			if (cur >= stop)
				busy <= 1'b0;
			else
				cur <= cur + 1'b1;
		end else if (wr_start) begin
			busy <= 1'b1;
			cur  <= wr_first;
			stop <= wr_last;
			egr  <= wr_egress;
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			for (int i = 0; i < depth; i++)
				tbl[i] <= '0;
		end else if (busy) begin
			tbl[cur] <= egr;
		end
	end

	assign lk_egress = tbl[lk_index];	// combinational, sees this cycle's contents

endmodule

/* hdl/egress_stamper.sv */
module egress_stamper #(
	parameter int DATA_WIDTH  = 512,
	parameter int TUSER_WIDTH = 128
) (
	input  logic                                clk,
	input  logic                                aresetn,

	input  logic [DATA_WIDTH-1:0]               d_tdata,
	input  logic [DATA_WIDTH/8-1:0]             d_tkeep,
	input  logic [TUSER_WIDTH-1:0]              d_tuser,
	input  logic                                d_tvalid,
	output logic                                d_tready,
	input  logic                                d_tlast,

	output logic [filter_pkg::table_idx_w-1:0]  lk_index,
	input  logic [filter_pkg::egress_w-1:0]     lk_egress,

	output logic [DATA_WIDTH-1:0]               m_tdata,
	output logic [DATA_WIDTH/8-1:0]             m_tkeep,
	output logic [TUSER_WIDTH-1:0]              m_tuser,
	output logic                                m_tvalid,
	input  logic                                m_tready,
	output logic                                m_tlast
);

	logic d_first;	// next data beat opens a packet
	logic d_fire;

	assign d_tready = ~m_tvalid | m_tready;
	assign d_fire   = d_tvalid & d_tready;

	// only the first beat carries the udp header, later beats ignore this
	assign lk_index = d_tdata[filter_pkg::udp_dport_lsb +: filter_pkg::table_idx_w];

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			d_first  <= 1'b1;
			m_tvalid <= 1'b0;
		end else begin
			if (d_fire) begin
				d_first  <= d_tlast;
				m_tvalid <= 1'b1;
			end else if (m_tready) begin
				m_tvalid <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// output register, stamps egress on the first beat
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (d_fire) begin
			m_tdata <= d_tdata;
			m_tkeep <= d_tkeep;
			m_tlast <= d_tlast;
			m_tuser <= d_tuser;
			if (d_first)
				m_tuser[filter_pkg::egress_lsb +: filter_pkg::egress_w] <= lk_egress;
		end
	end

endmodule

/* hdl/filter_top.sv */
module filter_top #(
	parameter int DATA_WIDTH  = 512,
	parameter int TUSER_WIDTH = 128
) (
	input  logic                    clk,
	input  logic                    aresetn,

	input  logic [DATA_WIDTH-1:0]   s_tdata,
	input  logic [DATA_WIDTH/8-1:0] s_tkeep,
	input  logic [TUSER_WIDTH-1:0]  s_tuser,
	input  logic                    s_tvalid,
	output logic                    s_tready,
	input  logic                    s_tlast,

	output logic [DATA_WIDTH-1:0]   m_tdata,
	output logic [DATA_WIDTH/8-1:0] m_tkeep,
	output logic [TUSER_WIDTH-1:0]  m_tuser,
	output logic                    m_tvalid,
	input  logic                    m_tready,
	output logic                    m_tlast
);

	// data path between filter and stamper
	logic [DATA_WIDTH-1:0]   d_tdata;
	logic [DATA_WIDTH/8-1:0] d_tkeep;
	logic [TUSER_WIDTH-1:0]  d_tuser;
	logic                    d_tvalid;
	logic                    d_tready;
	logic                    d_tlast;

	// control path, always accepted
	logic [DATA_WIDTH-1:0]   c_tdata;
	logic                    c_tvalid;
	logic                    c_tlast;

	logic                                wr_start;
	logic [filter_pkg::table_idx_w-1:0]  wr_first;
	logic [filter_pkg::table_idx_w-1:0]  wr_last;
	logic [filter_pkg::egress_w-1:0]     wr_egress;
	logic                                busy;
	logic [filter_pkg::table_idx_w-1:0]  lk_index;
	logic [filter_pkg::egress_w-1:0]     lk_egress;

	pkt_filter #(.DATA_WIDTH(DATA_WIDTH), .TUSER_WIDTH(TUSER_WIDTH)) u_pkt_filter (
		.clk(clk), .aresetn(aresetn),
		.s_tdata(s_tdata), .s_tkeep(s_tkeep), .s_tuser(s_tuser),
		.s_tvalid(s_tvalid), .s_tready(s_tready), .s_tlast(s_tlast),
		.d_tdata(d_tdata), .d_tkeep(d_tkeep), .d_tuser(d_tuser),
		.d_tvalid(d_tvalid), .d_tready(d_tready), .d_tlast(d_tlast),
		.c_tdata(c_tdata), .c_tvalid(c_tvalid), .c_tlast(c_tlast)
	);

	ctrl_decoder #(.DATA_WIDTH(DATA_WIDTH)) u_ctrl_decoder (
		.clk(clk), .aresetn(aresetn),
		.c_tdata(c_tdata), .c_tvalid(c_tvalid), .c_tlast(c_tlast), .busy(busy),
		.wr_start(wr_start), .wr_first(wr_first), .wr_last(wr_last), .wr_egress(wr_egress)
	);

	port_table u_port_table (
		.clk(clk), .aresetn(aresetn),
		.wr_start(wr_start), .wr_first(wr_first), .wr_last(wr_last), .wr_egress(wr_egress),
		.busy(busy), .lk_index(lk_index), .lk_egress(lk_egress)
	);

	egress_stamper #(.DATA_WIDTH(DATA_WIDTH), .TUSER_WIDTH(TUSER_WIDTH)) u_egress_stamper (
		.clk(clk), .aresetn(aresetn),
		.d_tdata(d_tdata), .d_tkeep(d_tkeep), .d_tuser(d_tuser),
		.d_tvalid(d_tvalid), .d_tready(d_tready), .d_tlast(d_tlast),
		.lk_index(lk_index), .lk_egress(lk_egress),
		.m_tdata(m_tdata), .m_tkeep(m_tkeep), .m_tuser(m_tuser),
		.m_tvalid(m_tvalid), .m_tready(m_tready), .m_tlast(m_tlast)
	);

endmodule

/* verification/tb_pkt_gen.svh */
localparam logic [15:0] ref_ipv4     = 16'h0008;	// ethertype 0x0800 as it sits in the beat
localparam logic [7:0]  ref_udp      = 8'h11;
localparam logic [15:0] ref_ctl_port = 16'hf2f1;

function automatic logic [31:0] xorshift(input logic [31:0] x);
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function automatic logic [31:0] next_rand();
	rng = xorshift(rng);
	return rng;
endfunction

// random upper bits, never the control port
function automatic logic [15:0] data_port(input logic [5:0] idx);
	logic [15:0] p;
	p = 16'(next_rand());
	p[5:0] = idx;
	if (p == ref_ctl_port)
		p[15] = ~p[15];
	return p;
endfunction

function automatic logic [31:0] write_cmd(input logic [5:0] idx, input logic [7:0] egr);
	return {16'h0, egr, idx, 2'd1};
endfunction

function automatic logic [31:0] fill_cmd(input logic [5:0] first, input logic [5:0] last,
		input logic [7:0] egr);
	return {8'h0, egr, 2'b0, last, first, 2'd2};
endfunction

// kind 0 is not ipv4, kind 1 is not udp, kind 2 is udp
function automatic void build_packet(input int kind, input logic [15:0] dport,
		input logic [31:0] cmd);
	plen = int'(next_rand() % 32'd4) + 1;
	for (int b = 0; b < plen; b++) begin
		for (int w = 0; w < 16; w++)
			pd[b][w*32 +: 32] = next_rand();
		for (int w = 0; w < 4; w++)
			pu[b][w*32 +: 32] = next_rand();
		pk[b] = '1;
	end
	pk[plen-1] = {32'h0, next_rand() | 32'h1};
	pd[0][143:128] = (kind == 0) ? 16'hdd86 : ref_ipv4;
	pd[0][223:216] = (kind == 1) ? 8'h06 : ref_udp;
	pd[0][335:320] = dport;
	pd[0][367:336] = cmd;
endfunction

function automatic void update_model(input logic [31:0] cmd);
	int f;
	int l;
	f = int'(cmd[7:2]);
	l = int'(cmd[13:8]);
	if (cmd[1:0] == 2'd1) begin
		model[f] = cmd[15:8];
	end else if (cmd[1:0] == 2'd2) begin
		if (f > l)
			model[f] = cmd[23:16];	// reversed range touches first only
		else
			for (int i = f; i <= l; i++)
				model[i] = cmd[23:16];
	end
endfunction

function automatic void expected_beats();
	logic [127:0] u;
	if (pd[0][143:128] != ref_ipv4 || pd[0][223:216] != ref_udp)
		return;
	if (pd[0][335:320] == ref_ctl_port) begin
		update_model(pd[0][367:336]);
		return;
	end
	for (int b = 0; b < plen; b++) begin
		u = pu[b];
		if (b == 0)
			u[31:24] = model[pd[0][325:320]];
		exp_data.push_back(pd[b]);
		exp_keep.push_back(pk[b]);
		exp_user.push_back(u);
		exp_last.push_back(b == plen - 1);
	end
endfunction

/* verification/tb_filter_top.sv */
module tb_filter_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int max_cycles = 20000;	// the traffic below needs some 2500 cycles at most

	logic         clk = 1'b0;
	logic         aresetn;
	logic [511:0] s_tdata;
	logic [63:0]  s_tkeep;
	logic [127:0] s_tuser;
	logic         s_tvalid;
	logic         s_tready;
	logic         s_tlast;
	logic [511:0] m_tdata;
	logic [63:0]  m_tkeep;
	logic [127:0] m_tuser;
	logic         m_tvalid;
	logic         m_tready;
	logic         m_tlast;

	logic [31:0]  rng;
	logic [31:0]  rdy_rng;
	logic         rand_ready;
	int           cycles = 0;
	string        test_name;
	logic [7:0]   model [64];
	logic [511:0] pd [4];	// packet under construction
	logic [63:0]  pk [4];
	logic [127:0] pu [4];
	int           plen;
	logic [511:0] exp_data [$];
	logic [63:0]  exp_keep [$];
	logic [127:0] exp_user [$];
	logic         exp_last [$];

	`include "tb_pkt_gen.svh"

	filter_top #(.DATA_WIDTH(512), .TUSER_WIDTH(128)) i_filter_top (
		.clk(clk), .aresetn(aresetn),
		.s_tdata(s_tdata), .s_tkeep(s_tkeep), .s_tuser(s_tuser),
		.s_tvalid(s_tvalid), .s_tready(s_tready), .s_tlast(s_tlast),
		.m_tdata(m_tdata), .m_tkeep(m_tkeep), .m_tuser(m_tuser),
		.m_tvalid(m_tvalid), .m_tready(m_tready), .m_tlast(m_tlast)
	);

	always #2 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic mismatch(input string field, input logic [511:0] e, input logic [511:0] a);
		fail_run($sformatf("MISMATCH %s %s expected %0h actual %0h", test_name, field, e, a));
	endtask

	////////////////////////////////////////////////////////////
	// output side
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		rdy_rng = xorshift(rdy_rng);
		m_tready = rand_ready ? rdy_rng[7] : 1'b1;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles)
			fail_run($sformatf("timeout after %0d cycles, the run stopped making progress", cycles));
	end

	always @(posedge clk) begin
		if (m_tvalid && m_tready) begin
			assert (exp_data.size() != 0) else fail_run({"unexpected output beat in ", test_name});
			assert (m_tdata == exp_data[0]) else mismatch("tdata", exp_data[0], m_tdata);
			assert (m_tkeep == exp_keep[0]) else mismatch("tkeep", 512'(exp_keep[0]), 512'(m_tkeep));
			assert (m_tuser == exp_user[0]) else mismatch("tuser", 512'(exp_user[0]), 512'(m_tuser));
			assert (m_tlast == exp_last[0]) else mismatch("tlast", 512'(exp_last[0]), 512'(m_tlast));
			void'(exp_data.pop_front());
			void'(exp_keep.pop_front());
			void'(exp_user.pop_front());
			void'(exp_last.pop_front());
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	task automatic send_packet();
		for (int b = 0; b < plen; b++) begin
			@(negedge clk);
			s_tdata = pd[b];
			s_tkeep = pk[b];
			s_tuser = pu[b];
			s_tlast = (b == plen - 1);
			s_tvalid = 1'b1;
			@(posedge clk);
			while (!s_tready)
				@(posedge clk);
		end
		@(negedge clk);
		s_tvalid = 1'b0;
	endtask

	task automatic wait_drained();
		while (exp_data.size() != 0)
			@(posedge clk);
	endtask

	task automatic data_packet(input int kind, input logic [5:0] idx);
		build_packet(kind, data_port(idx), next_rand());
		expected_beats();
		send_packet();
	endtask

	// table writes must not overtake data still in flight
	task automatic ctrl_packet(input logic [31:0] cmd);
		wait_drained();
		build_packet(2, ref_ctl_port, cmd);
		expected_beats();
		send_packet();
		repeat (80) @(posedge clk);
	endtask

	initial begin
		int          kind;
		logic [31:0] c;
		aresetn = 1'b0;
		s_tdata = '0;
		s_tkeep = '0;
		s_tuser = '0;
		s_tvalid = 1'b0;
		s_tlast = 1'b0;
		m_tready = 1'b0;
		rand_ready = 1'b0;
		rng = 32'h49426e95;
		rdy_rng = xorshift(~rng);
		test_name = "reset";
		for (int i = 0; i < 64; i++)
			model[i] = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		assert (!s_tready && !m_tvalid) else fail_run("s_tready or m_tvalid not low during reset");
		aresetn = 1'b1;

		test_name = "drop";
		repeat (4) data_packet(0, 6'(next_rand()));
		repeat (4) data_packet(1, 6'(next_rand()));
		repeat (4) @(posedge clk);	// two cycles of latency let a forwarded beat show up here

		test_name = "reset_table";
		repeat (8) data_packet(2, 6'(next_rand()));

		test_name = "write_entry";
		ctrl_packet(write_cmd(6'd5, 8'h3c));
		for (int i = 4; i <= 6; i++)
			data_packet(2, 6'(i));

		test_name = "fill_range";
		ctrl_packet(fill_cmd(6'd10, 6'd20, 8'ha5));
		for (int i = 8; i <= 22; i++)
			data_packet(2, 6'(i));
		ctrl_packet(fill_cmd(6'd40, 6'd30, 8'h77));
		for (int i = 28; i <= 42; i++)
			data_packet(2, 6'(i));

		test_name = "nop";
		ctrl_packet({16'h0, 8'h99, 6'd5, 2'd0});
		data_packet(2, 6'd5);

		test_name = "random_ready";
		rand_ready = 1'b1;
		repeat (60) begin
			kind = int'(next_rand() % 32'd8);
			c = next_rand();
			if (c[1:0] == 2'd3)
				c[1] = 1'b0;
			if (kind == 0)
				ctrl_packet(c);
			else if (kind < 6)
				data_packet(2, 6'(next_rand()));
			else
				data_packet(kind - 6, 6'(next_rand()));	// non-ipv4 or non-udp drop
		end

		// beats still missing after this long were lost in the DUT
		for (int i = 0; i < 200 && exp_data.size() != 0; i++)
			@(posedge clk);
		rand_ready = 1'b0;
		repeat (4) @(posedge clk);	// room for a duplicated beat to show up

		if (exp_data.size() == 0) begin
			$display("No errors");
			$finish;
		end else begin
			fail_run("expected beats never reached the output");
		end
	end

endmodule

/* tb.f */
+incdir+verification
hdl/filter_pkg.sv
hdl/pkt_filter.sv
hdl/ctrl_decoder.sv
hdl/port_table.sv
hdl/egress_stamper.sv
hdl/filter_top.sv
verification/tb_filter_top.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tb_filter_top -o tb_filter_top &&
./obj_dir/tb_filter_top || { echo "simulation failed"; exit 1; }
